//--- compile.f
logic/forward_data_pkg.sv
logic/forward_data_decode.sv
logic/forward_data_execute.sv
logic/forward_data_result.sv
logic/engine_forward_data.sv
testbench/engine_forward_data_properties.sv
testbench/tb_engine_forward_data.sv

//--- Makefile
# Verilator build and run of the forward-data engine testbench

TOP := tb_engine_forward_data

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_engine_forward_data.sv
/*
  Testbench for the forward-data engine top level.
  Drives a descriptor, directed packets and an LFSR packet burst, and
  predicts every output with a reference model of the forwarding rule.
  A negedge process checks each output packet, its latency and done.
*/
`timescale 1ns/100ps

module tb_engine_forward_data;

    import forward_data_pkg::*;

    logic               ap_clk;
    logic               areset;
    kernel_descriptor_t descriptor_in;
    engine_packet_t     response_engine_in;
    engine_packet_t     request_engine_out;
    logic               fifo_setup_signal;
    logic               done_out;

    // Model state
    engine_packet_t      expected_q[$];
    int                  expected_cycle_q[$];
    logic [seq_w-1:0]    expected_seq;
    logic [vertex_w-1:0] vertex_count_exp;
    logic [31:0]         lfsr_state;
    logic [31:0]         bits;
    engine_packet_t      popped;
    engine_packet_payload_t payload;
    int                  popped_cycle;
    int                  cycle_count = 0;
    int                  out_count;
    int                  wait_cycles;
    logic                checking;

    engine_forward_data dut_i (
        .ap_clk             (ap_clk),
        .areset             (areset),
        .descriptor_in      (descriptor_in),
        .response_engine_in (response_engine_in),
        .request_engine_out (request_engine_out),
        .fifo_setup_signal  (fifo_setup_signal),
        .done_out           (done_out)
    );

    bind engine_forward_data engine_forward_data_properties properties_i (
        .ap_clk                     (ap_clk),
        .areset_forward_data_engine (areset_forward_data_engine),
        .request_engine_out         (request_engine_out),
        .fifo_setup_signal          (fifo_setup_signal),
        .done_out                   (done_out)
    );

    // 4 ns clock
    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
    end

    // ------------------------------------------------------------------------
    // Reference model and random source
    // ------------------------------------------------------------------------
    // Forwarding rule, valid clear when nothing comes out
    function automatic engine_packet_t predict_output(
        input engine_packet_payload_t pkt,
        input logic [vertex_w-1:0]    vertex_count,
        input logic [seq_w-1:0]       seq
    );
        engine_packet_t result;
        int             next_bundle;
        next_bundle = (int'(pkt.route.dest_bundle) + 1) % num_bundles;
        result.payload = pkt;
        result.payload.route.dest_bundle = bundle_w'(next_bundle);
        result.payload.route.id_engine = engine_id_w'(id_engine_local);
        result.payload.seq = seq;
        result.valid = (pkt.cmd == cmd_data) && (pkt.vertex_id < vertex_count);
        return result;
    endfunction

    // Galois LFSR, taps 32,22,2,1
    function automatic logic [31:0] step_lfsr(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = step_lfsr(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_packet(input string name, input engine_packet_t expected,
                                  input engine_packet_t actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            report_failure("output packet mismatch");
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
            report_failure("flag mismatch");
        end
    endtask

    // Outputs settle by the falling edge
    always @(negedge ap_clk) begin
        if (checking) begin
            if (request_engine_out.valid === 1'b1) begin
                if (expected_q.size() == 0) begin
                    report_failure("DUT sent a packet that should not exist");
                end else begin
                    popped = expected_q.pop_front();
                    popped_cycle = expected_cycle_q.pop_front();
                    compare_packet("request_engine_out", popped, request_engine_out);
                    if (cycle_count != popped_cycle) begin
                        report_failure($sformatf("packet came out at cycle %0d instead of %0d",
                                                 cycle_count, popped_cycle));
                    end
                    out_count = out_count + 1;
                end
            end
            compare_bit("done_out",
                        (vertex_count_exp != 0) && (out_count >= int'(vertex_count_exp)),
                        done_out);
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    // Drive one packet for one cycle and record what must come out
    task automatic send_packet(input engine_packet_payload_t pkt);
        engine_packet_t expected;
        response_engine_in.valid = 1'b1;
        response_engine_in.payload = pkt;
        expected = predict_output(pkt, vertex_count_exp, expected_seq);
        if (expected.valid) begin
            expected_q.push_back(expected);
            expected_cycle_q.push_back(cycle_count + 4);
            expected_seq = expected_seq + 1'b1;
        end
        @(posedge ap_clk);
        #1;
    endtask

    // Foreign id and seq so the rewrite is visible
    function automatic engine_packet_payload_t make_payload(input engine_cmd_t cmd,
        input logic [vertex_w-1:0] vertex, input logic [1:0] bundle, input logic [1:0] lane);
        engine_packet_payload_t pkt;
        pkt.route.dest_bundle = bundle;
        pkt.route.dest_lane = lane;
        pkt.route.id_engine = 4'ha;
        pkt.cmd = cmd;
        pkt.seq = 16'hbeef;
        pkt.vertex_id = vertex;
        pkt.value = {16'hc0de, vertex};
        return pkt;
    endfunction

    task automatic drain_outputs(input int max_cycles);
        wait_cycles = 0;
        response_engine_in.valid = 1'b0;
        while (expected_q.size() != 0 && wait_cycles < max_cycles) begin
            @(negedge ap_clk);
            wait_cycles = wait_cycles + 1;
        end
        if (expected_q.size() != 0) begin
            report_failure("timed out waiting for output packets");
        end
        @(posedge ap_clk);
        #1;
    endtask

    initial begin
        areset = 1'b1;
        descriptor_in = '0;
        response_engine_in = '0;
        lfsr_state = 32'ha0a401c2;
        expected_seq = '0;
        vertex_count_exp = '0;
        out_count = 0;
        checking = 1'b0;

        repeat (2) @(posedge ap_clk);
        #1 areset = 1'b0;
        // Local reset copy is one clock behind
        @(posedge ap_clk);
        @(negedge ap_clk);
        compare_bit("request_engine_out.valid", 1'b0, request_engine_out.valid);
        compare_bit("done_out", 1'b0, done_out);
        compare_bit("fifo_setup_signal", 1'b1, fifo_setup_signal);
        checking = 1'b1;

        // Descriptor then setup flag
        @(posedge ap_clk);
        #1;
        descriptor_in.valid = 1'b1;
        descriptor_in.payload.vertex_count = 16'd24;
        vertex_count_exp = 16'd24;
        @(posedge ap_clk);
        #1;
        descriptor_in.valid = 1'b0;
        wait_cycles = 0;
        while (fifo_setup_signal !== 1'b0 && wait_cycles < 2) begin
            @(negedge ap_clk);
            wait_cycles = wait_cycles + 1;
        end
        if (fifo_setup_signal !== 1'b0) begin
            report_failure("fifo_setup_signal did not fall after the descriptor");
        end
        @(posedge ap_clk);
        #1;

        // Directed, including wrap and range edges
        send_packet(make_payload(cmd_data, 16'd0, 2'd0, 2'd1));
        send_packet(make_payload(cmd_data, 16'd5, 2'd3, 2'd2));
        send_packet(make_payload(cmd_drop, 16'd1, 2'd1, 2'd0));
        send_packet(make_payload(cmd_nop, 16'd2, 2'd2, 2'd3));
        send_packet(make_payload(cmd_data, 16'd24, 2'd0, 2'd0));
        send_packet(make_payload(cmd_data, 16'd300, 2'd1, 2'd1));
        send_packet(make_payload(cmd_data, 16'd23, 2'd1, 2'd3));
        drain_outputs(12);

        // Back-to-back burst, code 3 also sent as data
        for (int n = 0; n < 200; n++) begin
            take_random_bits(2, bits);
            payload.cmd = (bits[1:0] == 2'b11) ? cmd_data : engine_cmd_t'(bits[1:0]);
            take_random_bits(5, bits);
            payload.vertex_id = {11'd0, bits[4:0]};
            take_random_bits(32, bits);
            payload.value = bits;
            take_random_bits(8, bits);
            payload.route = bits[7:0];
            take_random_bits(16, bits);
            payload.seq = bits[15:0];
            send_packet(payload);
        end
        drain_outputs(12);

        compare_bit("done_out", int'(expected_seq) >= int'(vertex_count_exp), done_out);
        if (expected_q.size() != 0) begin
            report_failure($sformatf("%0d expected packets never came out", expected_q.size()));
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule : tb_engine_forward_data

//--- testbench/engine_forward_data_properties.sv
/*
  Concurrent checks on the forward-data engine ports.
  Bound onto engine_forward_data, so it sees the local reset copy that
  every stage uses. Failures show up only as assertion errors.
*/
`timescale 1ns/100ps

module engine_forward_data_properties (
    input logic                             ap_clk,
    input logic                             areset_forward_data_engine,
    input forward_data_pkg::engine_packet_t request_engine_out,
    input logic                             fifo_setup_signal,
    input logic                             done_out
);

    // ------------------------------------------------------------------------
    // Reset behaviour
    // ------------------------------------------------------------------------
    // A reset cycle leaves no packet on the output
    assert property (@(posedge ap_clk) areset_forward_data_engine |=> !request_engine_out.valid)
        else $error("request_engine_out valid high after a reset cycle");

    // ------------------------------------------------------------------------
    // Sticky flags
    // ------------------------------------------------------------------------
    // Done only drops through reset
    assert property (@(posedge ap_clk) $fell(done_out) |-> $past(areset_forward_data_engine))
        else $error("done_out fell outside reset");

    // Setup flag only comes back through reset
    assert property (@(posedge ap_clk)
        $rose(fifo_setup_signal) |-> $past(areset_forward_data_engine))
        else $error("fifo_setup_signal rose outside reset");

endmodule : engine_forward_data_properties

//--- logic/engine_forward_data.sv
/*
  Forward-data engine top level for one lane of one bundle.
  Registers reset, descriptor and incoming packet once, then runs the
  packet through decode, execute and result. The result stage holds the
  output register, so every port of this block is registered.
  Input valid to output valid is four clocks.
*/
`timescale 1ns/100ps

module engine_forward_data (
    input  logic                                ap_clk,
    input  logic                                areset,
    input  forward_data_pkg::kernel_descriptor_t descriptor_in,
    input  forward_data_pkg::engine_packet_t     response_engine_in,
    output forward_data_pkg::engine_packet_t     request_engine_out,
    output logic                                fifo_setup_signal,
    output logic                                done_out
);

    import forward_data_pkg::*;

    // ------------------------------------------------------------------------
    // Internal signals
    // ------------------------------------------------------------------------
    logic                areset_forward_data_engine;
    kernel_descriptor_t  descriptor_in_reg;
    engine_packet_t      response_engine_in_reg;
    logic [vertex_w-1:0] vertex_count;

    // Stage to stage
    decoded_packet_t decoded_packet;
    engine_packet_t  executed_packet;

    // Local copy of the reset, shared by all stages
    always_ff @(posedge ap_clk) begin
        areset_forward_data_engine <= areset;
    end

    // ------------------------------------------------------------------------
    // Input registers
    // ------------------------------------------------------------------------
    // Valid bits cleared in reset
    always_ff @(posedge ap_clk) begin
        if (areset_forward_data_engine) begin
            descriptor_in_reg.valid      <= 1'b0;
            response_engine_in_reg.valid <= 1'b0;
        end else begin
            descriptor_in_reg.valid      <= descriptor_in.valid;
            response_engine_in_reg.valid <= response_engine_in.valid;
        end
    end

    // Payloads just follow the ports
    always_ff @(posedge ap_clk) begin
        descriptor_in_reg.payload      <= descriptor_in.payload;
        response_engine_in_reg.payload <= response_engine_in.payload;
    end

    // Vertex count held until the next descriptor
    always_ff @(posedge ap_clk) begin
        if (areset_forward_data_engine) begin
            vertex_count <= '0;
        end else if (descriptor_in_reg.valid) begin
            vertex_count <= descriptor_in_reg.payload.vertex_count;
        end
    end

    // ------------------------------------------------------------------------
    // Pipeline stages
    // ------------------------------------------------------------------------
    forward_data_decode decode_i (
        .ap_clk                     (ap_clk),
        .areset_forward_data_engine (areset_forward_data_engine),
        .vertex_count               (vertex_count),
        .packet_in                  (response_engine_in_reg),
        .decoded_out                (decoded_packet)
    );

    forward_data_execute execute_i (
        .ap_clk                     (ap_clk),
        .areset_forward_data_engine (areset_forward_data_engine),
        .decoded_in                 (decoded_packet),
        .packet_out                 (executed_packet)
    );

    forward_data_result result_i (
        .ap_clk                     (ap_clk),
        .areset_forward_data_engine (areset_forward_data_engine),
        .descriptor_valid           (descriptor_in_reg.valid),
        .vertex_count               (vertex_count),
        .packet_in                  (executed_packet),
        .request_engine_out         (request_engine_out),
        .fifo_setup_signal          (fifo_setup_signal),
        .done_out                   (done_out)
    );

endmodule : engine_forward_data

//--- logic/forward_data_result.sv
/*
  Result stage of the forward-data engine, one clock.
  Holds the output packet register, counts the packets it has sent,
  and raises done with the packet that brings that count to the vertex
  count. Done is sticky until reset. The FIFO setup flag is high from
  reset until the first registered descriptor.
*/
`timescale 1ns/100ps

module forward_data_result (
    input  logic                                  ap_clk,
    input  logic                                  areset_forward_data_engine,
    input  logic                                  descriptor_valid,
    input  logic [forward_data_pkg::vertex_w-1:0] vertex_count,
    input  forward_data_pkg::engine_packet_t      packet_in,
    output forward_data_pkg::engine_packet_t      request_engine_out,
    output logic                                  fifo_setup_signal,
    output logic                                  done_out
);

    import forward_data_pkg::*;

    // ------------------------------------------------------------------------
    // Forwarded count
    // ------------------------------------------------------------------------
    logic [vertex_w-1:0] forward_count;
    logic [vertex_w-1:0] forward_count_next;
    logic                last_packet;

    assign forward_count_next = forward_count + 1'b1;
    // This packet completes the kernel
    assign last_packet = packet_in.valid && (forward_count_next == vertex_count);

    // ------------------------------------------------------------------------
    // Control state
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_forward_data_engine) begin
            request_engine_out.valid <= 1'b0;
            forward_count            <= '0;
            done_out                 <= 1'b0;
            fifo_setup_signal        <= 1'b1;
        end else begin
            request_engine_out.valid <= packet_in.valid;
            if (packet_in.valid) begin
                forward_count <= forward_count_next;
            end
            // Sticky, a new descriptor does not clear it
            if (last_packet) begin
                done_out <= 1'b1;
            end
            // Setup done once a descriptor is seen
            if (descriptor_valid) begin
                fifo_setup_signal <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Output payload
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        request_engine_out.payload <= packet_in.payload;
    end

endmodule : forward_data_result

//--- logic/forward_data_execute.sv
/*
  Execute stage of the forward-data engine, one clock.
  Takes decoded packets, drops those without the forward flag, and for
  the rest rewrites the route to the next bundle, stamps the local
  engine id and a running sequence number. The sequence counter only
  moves on forwarded packets, starting at zero after reset.
*/
`timescale 1ns/100ps

module forward_data_execute (
    input  logic                              ap_clk,
    input  logic                              areset_forward_data_engine,
    input  forward_data_pkg::decoded_packet_t decoded_in,
    output forward_data_pkg::engine_packet_t  packet_out
);

    import forward_data_pkg::*;

    // ------------------------------------------------------------------------
    // Next-hop route and payload
    // ------------------------------------------------------------------------
    logic                   take;
    logic [seq_w-1:0]       seq_count;
    engine_route_t          route_next;
    engine_packet_payload_t payload_next;

    assign take = decoded_in.valid && decoded_in.forward;

    always_comb begin
        route_next = decoded_in.payload.route;
        // Bundle wraps around the ring of num_bundles
        if (decoded_in.payload.route.dest_bundle == bundle_w'(num_bundles - 1)) begin
            route_next.dest_bundle = '0;
        end else begin
            route_next.dest_bundle = decoded_in.payload.route.dest_bundle + 1'b1;
        end
        // Lane stays, source becomes this engine
        route_next.id_engine = engine_id_w'(id_engine_local);

        payload_next       = decoded_in.payload;
        payload_next.route = route_next;
        payload_next.seq   = seq_count;
    end

    // ------------------------------------------------------------------------
    // Sequence counter
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_forward_data_engine) begin
            seq_count <= '0;
        end else if (take) begin
            seq_count <= seq_count + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Stage register
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_forward_data_engine) begin
            packet_out.valid <= 1'b0;
        end else begin
            packet_out.valid <= take;
        end
    end

    always_ff @(posedge ap_clk) begin
        packet_out.payload <= payload_next;
    end

endmodule : forward_data_execute

//--- logic/forward_data_decode.sv
/*
  Decode stage of the forward-data engine, one clock.
  Classifies each incoming packet by command and checks its vertex id
  against the latched vertex count. The result is a registered forward
  flag travelling with the untouched payload, so later stages never
  repeat the test.
*/
`timescale 1ns/100ps

module forward_data_decode (
    input  logic                                         ap_clk,
    input  logic                                         areset_forward_data_engine,
    input  logic [forward_data_pkg::vertex_w-1:0]        vertex_count,
    input  forward_data_pkg::engine_packet_t             packet_in,
    output forward_data_pkg::decoded_packet_t            decoded_out
);

    import forward_data_pkg::*;

    // ------------------------------------------------------------------------
    // Classification
    // ------------------------------------------------------------------------
    logic is_data;
    logic in_range;
    logic forward_next;

    always_comb begin
        // Only data commands go on, drop and nop both stop here
        is_data  = (packet_in.payload.cmd == cmd_data);
        // Vertex ids run from 0 to vertex_count - 1
        in_range = (packet_in.payload.vertex_id < vertex_count);
        // Valid travels beside the flag, execute combines the two
        forward_next = is_data && in_range;
    end

    // ------------------------------------------------------------------------
    // Stage register
    // ------------------------------------------------------------------------
    // Control bits
    always_ff @(posedge ap_clk) begin
        if (areset_forward_data_engine) begin
            decoded_out.valid   <= 1'b0;
            decoded_out.forward <= 1'b0;
        end else begin
            decoded_out.valid   <= packet_in.valid;
            decoded_out.forward <= forward_next;
        end
    end

    // Payload passes through unchanged
    always_ff @(posedge ap_clk) begin
        decoded_out.payload <= packet_in.payload;
    end

endmodule : forward_data_decode

//--- logic/forward_data_pkg.sv
/*
  Shared definitions for the forward-data engine of one bundle lane.
  Holds the overlay constants, the command codes and the packed packet
  and descriptor structs used on the top ports and between the stages.
  Modules import it inside their body and use scoped names in headers.
*/
package forward_data_pkg;

    // ------------------------------------------------------------------------
    // Overlay constants
    // ------------------------------------------------------------------------
    localparam int num_bundles     = 4;
    localparam int id_engine_local = 3;

    // Field widths
    localparam int vertex_w    = 16;
    localparam int value_w     = 32;
    localparam int seq_w       = 16;
    localparam int bundle_w    = 2;
    localparam int lane_w      = 2;
    localparam int engine_id_w = 4;

    // ------------------------------------------------------------------------
    // Command codes
    // ------------------------------------------------------------------------
    // Zero is a nop so an all-zero packet does nothing
    typedef enum logic [1:0] {
        cmd_data = 2'b01,
        cmd_drop = 2'b10,
        cmd_nop  = 2'b00
    } engine_cmd_t;

    // ------------------------------------------------------------------------
    // Packet and descriptor structs
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [bundle_w-1:0]    dest_bundle;
        logic [lane_w-1:0]      dest_lane;
        logic [engine_id_w-1:0] id_engine;
    } engine_route_t;

    typedef struct packed {
        engine_route_t       route;
        engine_cmd_t         cmd;
        logic [seq_w-1:0]    seq;
        logic [vertex_w-1:0] vertex_id;
        logic [value_w-1:0]  value;
    } engine_packet_payload_t;

    typedef struct packed {
        logic                   valid;
        engine_packet_payload_t payload;
    } engine_packet_t;

    typedef struct packed {
        logic [vertex_w-1:0] vertex_count;
    } kernel_descriptor_payload_t;

    typedef struct packed {
        logic                       valid;
        kernel_descriptor_payload_t payload;
    } kernel_descriptor_t;

    // Decode to execute, forward flag already resolved
    typedef struct packed {
        logic                   valid;
        logic                   forward;
        engine_packet_payload_t payload;
    } decoded_packet_t;

endpackage : forward_data_pkg
